/* mem_soc_cfg.svh */
`ifndef MEM_SOC_CFG_SVH
`define MEM_SOC_CFG_SVH

// Address map with exclusive top bounds.
`define CLINT_BASE 32'h0200_0000
`define CLINT_TOP 32'h0200_C000
`define PRINT_BASE 32'h1000_0000
`define PRINT_TOP 32'h1000_1000
`define BRAM_BASE 32'h8000_0000
`define BRAM_TOP 32'h8000_1000

// RAM size in 32-bit words.
`define BRAM_WORDS 1024

// CLINT register offsets.
`define CLINT_MSIP_OFS 32'h0000_0000
`define CLINT_CMP_OFS 32'h0000_4000   // High word at +4.
`define CLINT_TIME_OFS 32'h0000_BFF8  // High word at +4.

`endif

/* mem_soc_pkg.sv */
package mem_soc_pkg;

  // Bus vector types.
  typedef logic [31:0] addr_t;  // Byte address.
  typedef logic [31:0] data_t;  // Bus data word.
  typedef logic [3:0] strb_t;   // Byte write strobes, zero for a read.

  // CLINT time base.
  typedef logic [63:0] tick_t;

  // Address decode result.
  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_BRAM,
    SEL_PRINT,
    SEL_CLINT
  } slave_sel_t;

endpackage

/* mem_bus_if.sv */
`timescale 1ns/10ps

interface mem_bus_if import mem_soc_pkg::*; ();

  logic valid;  // One-cycle request strobe.
  logic instr;  // Request is an instruction fetch.
  addr_t addr;
  data_t wdata;
  strb_t wstrb;
  data_t rdata;
  logic ready;  // One-cycle response strobe.

  modport master (
    output valid, instr, addr, wdata, wstrb,
    input rdata, ready
  );

  modport slave (
    input valid, instr, addr, wdata, wstrb,
    output rdata, ready
  );

endinterface

/* bus_crossbar.sv */
`timescale 1ns/10ps

`include "mem_soc_cfg.svh"

module bus_crossbar import mem_soc_pkg::*; (
  input logic clk,
  input logic rst,
  mem_bus_if.slave ibus,
  mem_bus_if.slave dbus,
  mem_bus_if.master bram_bus,
  mem_bus_if.master print_bus,
  mem_bus_if.master clint_bus
);

  // Bit positions in the per-slave flag vectors.
  localparam int OWN_BRAM = 0;
  localparam int OWN_PRINT = 1;
  localparam int OWN_CLINT = 2;

  slave_sel_t isel;
  slave_sel_t dsel;
  addr_t iaddr;
  addr_t daddr;
  logic [2:0] ireq;       // Requests forwarded this cycle.
  logic [2:0] dreq;
  logic [2:0] own_i_q;    // Slave owes the instruction side a ready.
  logic [2:0] own_d_q;
  logic [2:0] slv_ready;

  function automatic slave_sel_t decode(addr_t a);
    decode = (a >= `CLINT_BASE && a < `CLINT_TOP) ? SEL_CLINT :
             (a >= `PRINT_BASE && a < `PRINT_TOP) ? SEL_PRINT :
             (a >= `BRAM_BASE && a < `BRAM_TOP) ? SEL_BRAM : SEL_NONE;
  endfunction

  function automatic addr_t base_of(slave_sel_t s);
    case (s)
      SEL_CLINT: base_of = `CLINT_BASE;
      SEL_PRINT: base_of = `PRINT_BASE;
      SEL_BRAM:  base_of = `BRAM_BASE;
      default:   base_of = '0;
    endcase
  endfunction

  function automatic logic [2:0] onehot(slave_sel_t s, logic v);
    onehot = '0;
    case (s)
      SEL_BRAM:  onehot[OWN_BRAM] = v;
      SEL_PRINT: onehot[OWN_PRINT] = v;
      SEL_CLINT: onehot[OWN_CLINT] = v;
      default:   onehot = '0;
    endcase
  endfunction

  function automatic data_t pick(logic [2:0] hit, data_t b, data_t p, data_t c);
    pick = hit[OWN_BRAM] ? b :
           hit[OWN_PRINT] ? p :
           hit[OWN_CLINT] ? c : '0;
  endfunction

  ////////////////////////////////////////
  // Request decode

  assign isel = decode(ibus.addr);
  assign dsel = decode(dbus.addr);
  assign iaddr = ibus.addr - base_of(isel);  // Slave-relative address.
  assign daddr = dbus.addr - base_of(dsel);

  assign dreq = onehot(dsel, dbus.valid);
  assign ireq = onehot(isel, ibus.valid) & ~dreq;  // Data side wins a collision.

  ////////////////////////////////////////
  // Owner flags

  assign slv_ready = {clint_bus.ready, print_bus.ready, bram_bus.ready};

  always_ff @(posedge clk) begin
    if (!rst) begin
      own_i_q <= '0;
      own_d_q <= '0;
    end else begin
      own_i_q <= ibus.valid ? ireq : (own_i_q & ~slv_ready);
      own_d_q <= dbus.valid ? dreq : (own_d_q & ~slv_ready);
    end
  end

  ////////////////////////////////////////
  // Forwarding to the slaves

  always_comb begin
    bram_bus.valid = dreq[OWN_BRAM] | ireq[OWN_BRAM];
    bram_bus.instr = dreq[OWN_BRAM] ? dbus.instr : ibus.instr;
    bram_bus.addr = dreq[OWN_BRAM] ? daddr : iaddr;
    bram_bus.wdata = dreq[OWN_BRAM] ? dbus.wdata : ibus.wdata;
    bram_bus.wstrb = dreq[OWN_BRAM] ? dbus.wstrb : ibus.wstrb;

    print_bus.valid = dreq[OWN_PRINT] | ireq[OWN_PRINT];
    print_bus.instr = dreq[OWN_PRINT] ? dbus.instr : ibus.instr;
    print_bus.addr = dreq[OWN_PRINT] ? daddr : iaddr;
    print_bus.wdata = dreq[OWN_PRINT] ? dbus.wdata : ibus.wdata;
    print_bus.wstrb = dreq[OWN_PRINT] ? dbus.wstrb : ibus.wstrb;

    clint_bus.valid = dreq[OWN_CLINT] | ireq[OWN_CLINT];
    clint_bus.instr = dreq[OWN_CLINT] ? dbus.instr : ibus.instr;
    clint_bus.addr = dreq[OWN_CLINT] ? daddr : iaddr;
    clint_bus.wdata = dreq[OWN_CLINT] ? dbus.wdata : ibus.wdata;
    clint_bus.wstrb = dreq[OWN_CLINT] ? dbus.wstrb : ibus.wstrb;
  end

  ////////////////////////////////////////
  // Responses back to the owners

  always_comb begin
    ibus.ready = |(own_i_q & slv_ready);
    dbus.ready = |(own_d_q & slv_ready);
    ibus.rdata = pick(own_i_q & slv_ready, bram_bus.rdata, print_bus.rdata,
                      clint_bus.rdata);
    dbus.rdata = pick(own_d_q & slv_ready, bram_bus.rdata, print_bus.rdata,
                      clint_bus.rdata);
  end

endmodule

/* bram_mem.sv */
`timescale 1ns/10ps

`include "mem_soc_cfg.svh"

module bram_mem import mem_soc_pkg::*; (
  input logic clk,
  input logic rst,
  mem_bus_if.slave bus
);

  localparam int IDX_W = $clog2(`BRAM_WORDS);

  data_t mem [`BRAM_WORDS];
  logic [IDX_W-1:0] idx;
  logic wr_en;
  data_t rdata_q;
  logic ready_q;

  assign idx = bus.addr[IDX_W+1:2];  // Word index above the byte offset.

  // Fetches never write.
  assign wr_en = bus.valid && !bus.instr && (bus.wstrb != '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < $bits(strb_t); b++) begin
        if (bus.wstrb[b]) begin
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
    if (bus.valid) begin
      rdata_q <= wr_en ? '0 : mem[idx];  // Writes answer with zero.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= bus.valid;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;

endmodule

/* print_port.sv */
`timescale 1ns/10ps

module print_port (
  input logic clk,
  input logic rst,
  mem_bus_if.slave bus,
  output logic [7:0] char_o,
  output logic strobe_o
);

  logic wr_en;
  logic ready_q;

  assign wr_en = bus.valid && bus.wstrb[0];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      char_o <= bus.wdata[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      strobe_o <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      strobe_o <= wr_en;      // One pulse per character.
      ready_q <= bus.valid;
    end
  end

  // Write-only device.
  assign bus.rdata = '0;
  assign bus.ready = ready_q;

endmodule

/* clint_timer.sv */
`timescale 1ns/10ps

`include "mem_soc_cfg.svh"

module clint_timer import mem_soc_pkg::*; (
  input logic clk,
  input logic rst,
  mem_bus_if.slave bus,
  output logic msip_o,
  output logic mtip_o,
  output tick_t mtime_o
);

  tick_t mtime_q;
  tick_t mtimecmp_q;
  logic msip_q;
  logic wr_en;
  data_t rd_word;
  data_t rdata_q;
  logic ready_q;

  assign wr_en = bus.valid && (bus.wstrb != '0);

  ////////////////////////////////////////
  // Register read decode

  always_comb begin
    case (bus.addr)
      `CLINT_MSIP_OFS:     rd_word = {31'b0, msip_q};
      `CLINT_CMP_OFS:      rd_word = mtimecmp_q[31:0];
      `CLINT_CMP_OFS + 4:  rd_word = mtimecmp_q[63:32];
      `CLINT_TIME_OFS:     rd_word = mtime_q[31:0];
      `CLINT_TIME_OFS + 4: rd_word = mtime_q[63:32];
      default:             rd_word = '0;
    endcase
  end

  ////////////////////////////////////////
  // Timer and registers

  always_ff @(posedge clk) begin
    if (!rst) begin
      mtime_q <= '0;
      mtimecmp_q <= '1;  // No timer interrupt until programmed.
      msip_q <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      mtime_q <= mtime_q + 1'b1;
      ready_q <= bus.valid;
      if (wr_en && bus.addr == `CLINT_MSIP_OFS) begin
        msip_q <= bus.wdata[0];
      end
      if (wr_en && bus.addr == `CLINT_CMP_OFS) begin
        mtimecmp_q[31:0] <= bus.wdata;
      end
      if (wr_en && bus.addr == `CLINT_CMP_OFS + 4) begin
        mtimecmp_q[63:32] <= bus.wdata;
      end
    end
  end

  // Value as seen in the request cycle.
  always_ff @(posedge clk) begin
    if (bus.valid) begin
      rdata_q <= rd_word;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ready = ready_q;

  assign msip_o = msip_q;
  assign mtip_o = (mtime_q >= mtimecmp_q);  // Level.
  assign mtime_o = mtime_q;

endmodule

/* mem_soc.sv */
`timescale 1ns/10ps

module mem_soc import mem_soc_pkg::*; (
  input logic clk,
  input logic rst,
  input logic imem_valid_i,
  input logic imem_instr_i,
  input addr_t imem_addr_i,
  input data_t imem_wdata_i,
  input strb_t imem_wstrb_i,
  output data_t imem_rdata_o,
  output logic imem_ready_o,
  input logic dmem_valid_i,
  input logic dmem_instr_i,
  input addr_t dmem_addr_i,
  input data_t dmem_wdata_i,
  input strb_t dmem_wstrb_i,
  output data_t dmem_rdata_o,
  output logic dmem_ready_o,
  output logic [7:0] print_char_o,
  output logic print_strobe_o,
  output logic msip_o,
  output logic mtip_o,
  output tick_t mtime_o
);

  mem_bus_if ibus ();
  mem_bus_if dbus ();
  mem_bus_if bram_bus ();
  mem_bus_if print_bus ();
  mem_bus_if clint_bus ();

  ////////////////////////////////////////
  // Master ports

  assign ibus.valid = imem_valid_i;
  assign ibus.instr = imem_instr_i;
  assign ibus.addr = imem_addr_i;
  assign ibus.wdata = imem_wdata_i;
  assign ibus.wstrb = imem_wstrb_i;
  assign imem_rdata_o = ibus.rdata;
  assign imem_ready_o = ibus.ready;

  assign dbus.valid = dmem_valid_i;
  assign dbus.instr = dmem_instr_i;
  assign dbus.addr = dmem_addr_i;
  assign dbus.wdata = dmem_wdata_i;
  assign dbus.wstrb = dmem_wstrb_i;
  assign dmem_rdata_o = dbus.rdata;
  assign dmem_ready_o = dbus.ready;

  ////////////////////////////////////////
  // Crossbar and slaves

  bus_crossbar u_xbar (
    .clk       (clk),
    .rst       (rst),
    .ibus      (ibus.slave),
    .dbus      (dbus.slave),
    .bram_bus  (bram_bus.master),
    .print_bus (print_bus.master),
    .clint_bus (clint_bus.master)
  );

  bram_mem u_bram (
    .clk (clk),
    .rst (rst),
    .bus (bram_bus.slave)
  );

  print_port u_print (
    .clk      (clk),
    .rst      (rst),
    .bus      (print_bus.slave),
    .char_o   (print_char_o),
    .strobe_o (print_strobe_o)
  );

  clint_timer u_clint (
    .clk     (clk),
    .rst     (rst),
    .bus     (clint_bus.slave),
    .msip_o  (msip_o),
    .mtip_o  (mtip_o),
    .mtime_o (mtime_o)
  );

endmodule

/* mem_soc_chk.sv */
`timescale 1ns/10ps

module mem_soc_chk import mem_soc_pkg::*; (
  input logic clk,
  input logic rst,
  input logic ivalid,
  input logic dvalid,
  input slave_sel_t isel,
  input slave_sel_t dsel,
  input logic [2:0] ireq,
  input logic [2:0] dreq,
  input logic [2:0] own_i,
  input logic [2:0] own_d,
  input logic [2:0] slv_ready
);

  // A slave never owes both masters a ready.
  a_single_owner: assert property (@(posedge clk) disable iff (!rst)
    (own_i & own_d) == 3'b000)
    else $error("slave owned by both masters");

  // Every slave ready follows a forwarded valid by exactly one cycle.
  a_ready_latency: assert property (@(posedge clk) disable iff (!rst)
    slv_ready == $past(ireq | dreq))
    else $error("slave ready without a forwarded valid one cycle before");

  // Unmapped requests claim no slave and so never see a ready.
  a_unmapped_i: assert property (@(posedge clk) disable iff (!rst)
    (ivalid && isel == SEL_NONE) |=> !(|(own_i & slv_ready)))
    else $error("unmapped instruction request got a ready");

  a_unmapped_d: assert property (@(posedge clk) disable iff (!rst)
    (dvalid && dsel == SEL_NONE) |=> !(|(own_d & slv_ready)))
    else $error("unmapped data request got a ready");

endmodule

bind bus_crossbar mem_soc_chk u_chk (
  .clk       (clk),
  .rst       (rst),
  .ivalid    (ibus.valid),
  .dvalid    (dbus.valid),
  .isel      (isel),
  .dsel      (dsel),
  .ireq      (ireq),
  .dreq      (dreq),
  .own_i     (own_i_q),
  .own_d     (own_d_q),
  .slv_ready (slv_ready)
);

/* mem_soc_tb.sv */
`timescale 1ns/10ps

`include "mem_soc_cfg.svh"

module mem_soc_tb import mem_soc_pkg::*; ();

  // Roughly 130 cycles of tests plus the CLINT compare wait, with margin.
  localparam int MAX_CYCLES = 400;
  localparam int NWORDS = 8;

  logic clk;
  logic rst;
  logic imem_valid_i, imem_instr_i, dmem_valid_i, dmem_instr_i;
  addr_t imem_addr_i, dmem_addr_i;
  data_t imem_wdata_i, dmem_wdata_i;
  strb_t imem_wstrb_i, dmem_wstrb_i;
  data_t imem_rdata_o, dmem_rdata_o;
  logic imem_ready_o, dmem_ready_o;
  logic [7:0] print_char_o;
  logic print_strobe_o, msip_o, mtip_o;
  tick_t mtime_o;

  integer seed = 60;
  int cyc = 0;
  int errs = 0;
  int test_errs = 0;
  int tests = 0;
  int tests_failed = 0;
  string test_name = "reset";

  data_t ref_mem [`BRAM_WORDS];  // Reference RAM image.
  logic ref_msip = 1'b0;
  tick_t tick_ref;               // Expected mtime.
  logic i_pend = 0, d_pend = 0, i_got = 0, d_got = 0, d_chk = 0;
  data_t i_exp, d_exp, d_val;
  int n_strobe = 0;
  logic [7:0] last_char;

  mem_soc uut (.*);

  always #2 clk = ~clk;

  ////////////////////////////////////////
  // Reference model

  function automatic data_t merge(data_t old, data_t wd, strb_t st);
    data_t r;
    r = old;
    for (int b = 0; b < 4; b++) begin
      if (st[b]) r[8*b +: 8] = wd[8*b +: 8];
    end
    return r;
  endfunction

  function automatic data_t ref_read(addr_t a);
    if (a >= `BRAM_BASE && a < `BRAM_TOP) return ref_mem[(a - `BRAM_BASE) >> 2];
    if (a == `CLINT_BASE + `CLINT_MSIP_OFS) return {31'b0, ref_msip};
    return '0;  // Print port and unmapped space.
  endfunction

  ////////////////////////////////////////
  // Checks

  task automatic report_error(string msg);
    $display("Error in %s: %s", test_name, msg);
    errs++;
  endtask

  task automatic check_data(string what, data_t exp, data_t act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
      errs++;
    end
  endtask

  task automatic check_tick(string what, tick_t exp, tick_t act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
      errs++;
    end
  endtask

  task automatic check_bit(string what, logic exp, logic act);
    if (exp !== act) begin
      $display("Mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
      errs++;
    end
  endtask

  // Compare process for the responses.
  always @(negedge clk) begin
    if (rst) begin
      if (imem_ready_o) begin
        if (!i_pend) report_error("unexpected ready on the instruction port");
        else check_data("ifetch", i_exp, imem_rdata_o);
        i_got = 1;
      end
      if (dmem_ready_o) begin
        if (!d_pend) report_error("unexpected ready on the data port");
        else if (d_chk) check_data("data", d_exp, dmem_rdata_o);
        d_got = 1;
        d_val = dmem_rdata_o;
      end
      if (print_strobe_o) begin
        n_strobe++;
        last_char = print_char_o;
      end
    end
  end

  always @(posedge clk) begin
    if (!rst) tick_ref <= '0;
    else tick_ref <= tick_ref + 1;
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles in %s", cyc, test_name);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Bus drivers

  task automatic drive_i(addr_t a, logic pend);
    imem_valid_i = 1;
    imem_instr_i = 1;
    imem_addr_i = a;
    i_exp = ref_read(a);
    i_pend = pend;
    i_got = 0;
  endtask

  task automatic drive_d(addr_t a, data_t wd, strb_t st, logic pend, logic chk, data_t exp);
    dmem_valid_i = 1;
    dmem_addr_i = a;
    dmem_wdata_i = wd;
    dmem_wstrb_i = st;
    d_exp = exp;
    d_chk = chk;
    d_pend = pend;
    d_got = 0;
  endtask

  // Ends the request cycle and expects ready in the next one.
  task automatic wait_resp();
    @(negedge clk);
    imem_valid_i = 0;
    dmem_valid_i = 0;
    @(posedge clk);
    if (i_pend && !i_got) report_error("no ready on the instruction port one cycle after valid");
    if (d_pend && !d_got) report_error("no ready on the data port one cycle after valid");
    i_pend = 0;
    d_pend = 0;
  endtask

  task automatic write_d(addr_t a, data_t wd, strb_t st);
    @(negedge clk);
    drive_d(a, wd, st, 1, (a < `CLINT_BASE || a >= `CLINT_TOP), '0);
    wait_resp();
    if (a >= `BRAM_BASE && a < `BRAM_TOP) begin
      ref_mem[(a - `BRAM_BASE) >> 2] = merge(ref_mem[(a - `BRAM_BASE) >> 2], wd, st);
    end
  endtask

  task automatic read_d(addr_t a);
    @(negedge clk);
    drive_d(a, '0, '0, 1, 1, ref_read(a));
    wait_resp();
  endtask

  task automatic read_i(addr_t a);
    @(negedge clk);
    drive_i(a, 1);
    wait_resp();
  endtask

  task automatic begin_test(string name);
    test_name = name;
    test_errs = errs;
    tests++;
  endtask

  task automatic end_test();
    if (errs == test_errs) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: FAILED (%0d errors)", test_name, errs - test_errs);
      tests_failed++;
    end
  endtask

  ////////////////////////////////////////
  // Tests

  initial begin
    addr_t a;
    addr_t addrs [NWORDS];
    data_t t0;
    int c0;
    tick_t target;
    strb_t st;
    string msg;
    clk = 0;
    rst = 0;
    imem_valid_i = 0;
    imem_instr_i = 1;
    imem_addr_i = '0;
    imem_wdata_i = '0;
    imem_wstrb_i = '0;
    dmem_valid_i = 0;
    dmem_instr_i = 0;
    dmem_addr_i = '0;
    dmem_wdata_i = '0;
    dmem_wstrb_i = '0;
    repeat (4) @(negedge clk);
    rst = 1;

    begin_test("ram_round_trip");
    for (int k = 0; k < NWORDS; k++) begin
      addrs[k] = `BRAM_BASE + ((addr_t'($random(seed)) & 32'h3ff) << 2);
      write_d(addrs[k], $random(seed), 4'hf);  // Defines every byte first.
      do begin
        st = strb_t'($random(seed));
      end while (st == '0);  // A zero strobe would be a read.
      write_d(addrs[k], $random(seed), st);
    end
    for (int k = 0; k < NWORDS; k++) begin
      read_d(addrs[k]);
      read_i(addrs[k]);
    end
    end_test();

    begin_test("print_output");
    msg = "Hi!\n";
    foreach (msg[k]) begin
      c0 = n_strobe;
      write_d(`PRINT_BASE, data_t'(msg[k]), 4'h1);
      check_data("strobe count", data_t'(c0 + 1), data_t'(n_strobe));
      check_data("char", data_t'(msg[k]), data_t'(last_char));
    end
    end_test();

    begin_test("clint_registers");
    write_d(`CLINT_BASE + `CLINT_MSIP_OFS, 32'h1, 4'hf);
    ref_msip = 1;
    check_bit("msip", 1'b1, msip_o);
    @(negedge clk);
    check_tick("mtime", tick_ref, mtime_o);
    drive_d(`CLINT_BASE + `CLINT_TIME_OFS, '0, '0, 1, 1, tick_ref[31:0]);
    t0 = tick_ref[31:0];
    c0 = cyc;
    wait_resp();
    repeat (3) @(negedge clk);
    drive_d(`CLINT_BASE + `CLINT_TIME_OFS, '0, '0, 1, 1, tick_ref[31:0]);
    c0 = cyc - c0;
    wait_resp();
    check_data("mtime delta", data_t'(c0), d_val - t0);
    write_d(`CLINT_BASE + `CLINT_CMP_OFS + 4, 32'h0, 4'hf);
    target = tick_ref + 20;
    write_d(`CLINT_BASE + `CLINT_CMP_OFS, target[31:0], 4'hf);
    while (mtime_o < target) begin
      check_bit("mtip early", 1'b0, mtip_o);
      @(negedge clk);
    end
    check_bit("mtip", 1'b1, mtip_o);
    end_test();

    begin_test("collision");
    a = addrs[0];
    @(negedge clk);
    drive_i(a, 0);  // Loses to the data write.
    drive_d(a, 32'hC0FF_EE01, 4'hf, 1, 1, '0);
    wait_resp();
    ref_mem[(a - `BRAM_BASE) >> 2] = 32'hC0FF_EE01;
    read_i(a);
    end_test();

    begin_test("parallel_access");
    @(negedge clk);
    drive_i(addrs[1], 1);
    drive_d(`CLINT_BASE + `CLINT_MSIP_OFS, '0, '0, 1, 1, ref_read(`CLINT_BASE));
    wait_resp();
    end_test();

    begin_test("unmapped_address");
    @(negedge clk);
    drive_d(32'h4000_0000, '0, '0, 0, 0, '0);
    wait_resp();
    repeat (3) @(posedge clk);
    read_d(addrs[2]);
    end_test();

    @(negedge clk);
    $display("tests: %0d, failed: %0d, errors: %0d", tests, tests_failed, errs);
    if (errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* mem_soc.f */
+incdir+.
mem_soc_pkg.sv
mem_bus_if.sv
bus_crossbar.sv
bram_mem.sv
print_port.sv
clint_timer.sv
mem_soc.sv
mem_soc_chk.sv
mem_soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= mem_soc_tb
FLIST ?= mem_soc.f
BUILD ?= obj_dir
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST BUILD VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q "^Test passed$$"

clean:
	rm -rf $(BUILD)
